// File: logic/pvr_pkg.sv
package pvr_pkg;

	localparam int ADDR_W = 16;                          // host bus address width
	localparam int DATA_W = 32;                          // bus data word
	localparam int STRB_W = DATA_W / 8;                  // one strobe per byte

	localparam logic [ADDR_W-1:0] PAL_BASE = 16'h1000;   // palette window, bit 12 set

	// control register offsets, one word each
	localparam logic [ADDR_W-1:0] ID_ADDR              = 16'h0000; // device id, read only
	localparam logic [ADDR_W-1:0] REVISION_ADDR        = 16'h0004; // revision, read only
	localparam logic [ADDR_W-1:0] SOFTRESET_ADDR       = 16'h0008; // core and ta soft reset
	localparam logic [ADDR_W-1:0] STARTRENDER_ADDR     = 16'h0014; // drawing start
	localparam logic [ADDR_W-1:0] PARAM_BASE_ADDR      = 16'h0020; // isp parameter base
	localparam logic [ADDR_W-1:0] REGION_BASE_ADDR     = 16'h002C; // region array base
	localparam logic [ADDR_W-1:0] VO_BORDER_COL_ADDR   = 16'h0040; // border colour
	localparam logic [ADDR_W-1:0] FB_W_LINESTRIDE_ADDR = 16'h004C; // fb line stride
	localparam logic [ADDR_W-1:0] FB_R_SOF1_ADDR       = 16'h0050; // fb read start
	localparam logic [ADDR_W-1:0] FB_W_SOF1_ADDR       = 16'h0060; // fb write start
	localparam logic [ADDR_W-1:0] FB_X_CLIP_ADDR       = 16'h0068; // pixel clip x
	localparam logic [ADDR_W-1:0] FB_Y_CLIP_ADDR       = 16'h006C; // pixel clip y
	localparam logic [ADDR_W-1:0] FPU_PARAM_CFG_ADDR   = 16'h007C; // parameter read control
	localparam logic [ADDR_W-1:0] TA_ALLOC_CTRL_ADDR   = 16'h0140; // object list alloc

	localparam logic [DATA_W-1:0] DEVICE_ID         = 32'h17FD11DB;
	localparam logic [DATA_W-1:0] REVISION_ID       = 32'h00000011;
	localparam logic [DATA_W-1:0] RST_FPU_PARAM_CFG = 32'h0027DF77;
	localparam logic [DATA_W-1:0] RST_TA_ALLOC_CTRL = 32'h00100303;
	localparam logic [DATA_W-1:0] RST_REGION_BASE   = 32'h001667C0;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10,                                  // write to a read-only word
		DECERR = 2'b11                                   // nobody claimed the address
	} resp_t;

	typedef struct packed {
		logic              valid;
		logic              write;                        // 1 write, 0 read
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic [STRB_W-1:0] strb;
	} bus_req_t;

	typedef struct packed {
		logic              hit;                          // address decoded by this part
		logic              ro_violation;
		logic [DATA_W-1:0] rdata;
	} store_rsp_t;

	typedef struct packed {
		logic [DATA_W-1:0] param_base;
		logic [DATA_W-1:0] region_base;
		logic [DATA_W-1:0] fpu_param_cfg;
		logic [DATA_W-1:0] ta_alloc_ctrl;
	} parser_cfg_t;

	// merge the enabled bytes of new_word into old_word
	function automatic logic [DATA_W-1:0] apply_strb(input logic [DATA_W-1:0] old_word,
		input logic [DATA_W-1:0] new_word, input logic [STRB_W-1:0] strb);
		logic [DATA_W-1:0] merged;
		merged = old_word;
		for (int b = 0; b < STRB_W; b++) begin
			if (strb[b]) merged[8*b +: 8] = new_word[8*b +: 8];
		end
		return merged;
	endfunction

endpackage

// File: logic/pvr_reg_bank.sv
`timescale 1ns/1ps

module pvr_reg_bank #(
	parameter int ADDR_W = pvr_pkg::ADDR_W
) (
	input  logic                 clock,
	input  logic                 reset_n,
	input  pvr_pkg::bus_req_t    req_i,
	output pvr_pkg::store_rsp_t  rsp_o,
	output pvr_pkg::parser_cfg_t cfg_o,
	output logic                 start_render_o
);
	import pvr_pkg::*;

	logic [ADDR_W-1:0] word_addr;       // byte lanes dropped
	logic              wr_en;
	logic              sel;             // offset is a kept register
	logic              ro_hit;          // write aimed at id or revision
	logic [DATA_W-1:0] rd_word;
	logic              hit_q;
	logic              ro_q;
	logic [DATA_W-1:0] rdata_q;

	logic [DATA_W-1:0] softreset;
	logic [DATA_W-1:0] startrender;
	logic [DATA_W-1:0] param_base;
	logic [DATA_W-1:0] region_base;
	logic [DATA_W-1:0] vo_border_col;
	logic [DATA_W-1:0] fb_w_linestride;
	logic [DATA_W-1:0] fb_r_sof1;
	logic [DATA_W-1:0] fb_w_sof1;
	logic [DATA_W-1:0] fb_x_clip;
	logic [DATA_W-1:0] fb_y_clip;
	logic [DATA_W-1:0] fpu_param_cfg;
	logic [DATA_W-1:0] ta_alloc_ctrl;

	assign word_addr = {req_i.addr[ADDR_W-1:2], 2'b00};
	assign wr_en     = req_i.valid & req_i.write;
	assign ro_hit    = req_i.write & ((word_addr == ID_ADDR) | (word_addr == REVISION_ADDR));

	always_comb begin
		sel     = 1'b1;
		rd_word = '0;
		case (word_addr)
			ID_ADDR:              rd_word = DEVICE_ID;      // constants, never stored
			REVISION_ADDR:        rd_word = REVISION_ID;
			SOFTRESET_ADDR:       rd_word = softreset;
			STARTRENDER_ADDR:     rd_word = startrender;
			PARAM_BASE_ADDR:      rd_word = param_base;
			REGION_BASE_ADDR:     rd_word = region_base;
			VO_BORDER_COL_ADDR:   rd_word = vo_border_col;
			FB_W_LINESTRIDE_ADDR: rd_word = fb_w_linestride;
			FB_R_SOF1_ADDR:       rd_word = fb_r_sof1;
			FB_W_SOF1_ADDR:       rd_word = fb_w_sof1;
			FB_X_CLIP_ADDR:       rd_word = fb_x_clip;
			FB_Y_CLIP_ADDR:       rd_word = fb_y_clip;
			FPU_PARAM_CFG_ADDR:   rd_word = fpu_param_cfg;
			TA_ALLOC_CTRL_ADDR:   rd_word = ta_alloc_ctrl;
			default:              sel     = 1'b0;           // leave it to the palette or decerr
		endcase
	end

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			softreset       <= '0;
			startrender     <= '0;
			param_base      <= '0;
			region_base     <= RST_REGION_BASE;
			vo_border_col   <= '0;
			fb_w_linestride <= '0;
			fb_r_sof1       <= '0;
			fb_w_sof1       <= '0;
			fb_x_clip       <= '0;
			fb_y_clip       <= '0;
			fpu_param_cfg   <= RST_FPU_PARAM_CFG;
			ta_alloc_ctrl   <= RST_TA_ALLOC_CTRL;
			start_render_o  <= 1'b0;
		end else begin
			start_render_o <= wr_en & (word_addr == STARTRENDER_ADDR); // one cycle strobe
			if (wr_en) begin
				case (word_addr)
					SOFTRESET_ADDR:       softreset       <= apply_strb(softreset, req_i.wdata, req_i.strb);
					STARTRENDER_ADDR:     startrender     <= apply_strb(startrender, req_i.wdata, req_i.strb);
					PARAM_BASE_ADDR:      param_base      <= apply_strb(param_base, req_i.wdata, req_i.strb);
					REGION_BASE_ADDR:     region_base     <= apply_strb(region_base, req_i.wdata, req_i.strb);
					VO_BORDER_COL_ADDR:   vo_border_col   <= apply_strb(vo_border_col, req_i.wdata, req_i.strb);
					FB_W_LINESTRIDE_ADDR: fb_w_linestride <= apply_strb(fb_w_linestride, req_i.wdata, req_i.strb);
					FB_R_SOF1_ADDR:       fb_r_sof1       <= apply_strb(fb_r_sof1, req_i.wdata, req_i.strb);
					FB_W_SOF1_ADDR:       fb_w_sof1       <= apply_strb(fb_w_sof1, req_i.wdata, req_i.strb);
					FB_X_CLIP_ADDR:       fb_x_clip       <= apply_strb(fb_x_clip, req_i.wdata, req_i.strb);
					FB_Y_CLIP_ADDR:       fb_y_clip       <= apply_strb(fb_y_clip, req_i.wdata, req_i.strb);
					FPU_PARAM_CFG_ADDR:   fpu_param_cfg   <= apply_strb(fpu_param_cfg, req_i.wdata, req_i.strb);
					TA_ALLOC_CTRL_ADDR:   ta_alloc_ctrl   <= apply_strb(ta_alloc_ctrl, req_i.wdata, req_i.strb);
					default: ;                               // id, revision and unmapped ignored
				endcase
			end
		end
	end

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			hit_q <= 1'b0;
			ro_q  <= 1'b0;
		end else begin
			hit_q <= req_i.valid & sel;                 // answer one cycle after the request
			ro_q  <= req_i.valid & ro_hit;
		end
	end

	always_ff @(posedge clock) begin
		if (req_i.valid) rdata_q <= rd_word;            // value before any write this edge
	end

	assign rsp_o = '{hit: hit_q, ro_violation: ro_q, rdata: rdata_q};

	// the parser sees register contents directly
	assign cfg_o = '{param_base: param_base, region_base: region_base,
		fpu_param_cfg: fpu_param_cfg, ta_alloc_ctrl: ta_alloc_ctrl};

endmodule

// File: logic/pvr_palette_ram.sv
`timescale 1ns/1ps

module pvr_palette_ram #(
	parameter int ADDR_W    = pvr_pkg::ADDR_W,
	parameter int PAL_WORDS = 4096
) (
	input  logic                clock,
	input  logic                reset_n,
	input  pvr_pkg::bus_req_t   req_i,
	output pvr_pkg::store_rsp_t rsp_o
);
	import pvr_pkg::*;

	localparam int IDX_W     = $clog2(PAL_WORDS);
	localparam int PAL_LIMIT = int'(PAL_BASE) + 4 * PAL_WORDS; // first byte past the array

	logic [DATA_W-1:0] mem [PAL_WORDS];
	logic [ADDR_W-1:0] offset;          // byte offset inside the window
	logic [IDX_W-1:0]  idx;
	logic              in_win;
	logic              hit_q;
	logic [DATA_W-1:0] rdata_q;

	assign offset = req_i.addr - PAL_BASE;
	assign idx    = offset[IDX_W+1:2];
	assign in_win = (req_i.addr[ADDR_W-1:12] == PAL_BASE[ADDR_W-1:12])
		& (int'(req_i.addr) < PAL_LIMIT);           // depth may be smaller than the window

	always_ff @(posedge clock) begin
		if (req_i.valid & in_win) begin
			if (req_i.write) mem[idx] <= apply_strb(mem[idx], req_i.wdata, req_i.strb);
			rdata_q <= mem[idx];                        // registered read, old word on write
		end
	end

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			hit_q <= 1'b0;
		end else begin
			hit_q <= req_i.valid & in_win;
		end
	end

	assign rsp_o = '{hit: hit_q, ro_violation: 1'b0, rdata: rdata_q}; // all words writable

endmodule

// File: logic/pvr_axi_slave.sv
`timescale 1ns/1ps

module pvr_axi_slave #(
	parameter int ADDR_W = pvr_pkg::ADDR_W
) (
	input  logic                         clock,
	input  logic                         reset_n,
	// write address and data
	input  logic [ADDR_W-1:0]            s_awaddr_i,
	input  logic                         s_awvalid_i,
	output logic                         s_awready_o,
	input  logic [pvr_pkg::DATA_W-1:0]   s_wdata_i,
	input  logic [pvr_pkg::STRB_W-1:0]   s_wstrb_i,
	input  logic                         s_wvalid_i,
	output logic                         s_wready_o,
	// write response
	output pvr_pkg::resp_t               s_bresp_o,
	output logic                         s_bvalid_o,
	input  logic                         s_bready_i,
	// read address and data
	input  logic [ADDR_W-1:0]            s_araddr_i,
	input  logic                         s_arvalid_i,
	output logic                         s_arready_o,
	output logic [pvr_pkg::DATA_W-1:0]   s_rdata_o,
	output pvr_pkg::resp_t               s_rresp_o,
	output logic                         s_rvalid_o,
	input  logic                         s_rready_i,
	// storage side
	output pvr_pkg::bus_req_t            req_o,
	input  pvr_pkg::store_rsp_t          reg_rsp_i,
	input  pvr_pkg::store_rsp_t          pal_rsp_i
);
	import pvr_pkg::*;

	logic              wr_busy;         // write accepted, b not yet taken
	logic              rd_busy;         // read accepted, r not yet taken
	logic              aw_hs;
	logic              ar_hs;
	logic              b_hs;
	logic              r_hs;
	logic              rd_held;         // read lost the slot to a write this cycle
	logic [ADDR_W-1:0] rd_addr_q;
	logic              req_valid;
	logic              req_write;
	logic [ADDR_W-1:0] req_addr;
	logic [DATA_W-1:0] req_wdata;
	logic [STRB_W-1:0] req_strb;
	logic              ans_pend;        // storage answers this cycle
	logic              ans_write;       // ... and it belongs to the write channel
	logic              any_hit;
	logic [DATA_W-1:0] merged_data;
	resp_t             merged_resp;

	assign aw_hs = s_awvalid_i & s_wvalid_i & ~wr_busy;   // aw and w taken together
	assign ar_hs = s_arvalid_i & ~rd_busy;
	assign b_hs  = s_bvalid_o & s_bready_i;
	assign r_hs  = s_rvalid_o & s_rready_i;

	assign s_awready_o = aw_hs;
	assign s_wready_o  = aw_hs;
	assign s_arready_o = ar_hs;

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			wr_busy    <= 1'b0;
			rd_busy    <= 1'b0;
			rd_held    <= 1'b0;
			req_valid  <= 1'b0;
			ans_pend   <= 1'b0;
			s_bvalid_o <= 1'b0;
			s_rvalid_o <= 1'b0;
		end else begin
			if (aw_hs) wr_busy <= 1'b1;
			else if (b_hs) wr_busy <= 1'b0;
			if (ar_hs) rd_busy <= 1'b1;
			else if (r_hs) rd_busy <= 1'b0;
			rd_held   <= aw_hs & ar_hs;                 // write goes first, read next cycle
			req_valid <= aw_hs | ar_hs | rd_held;
			ans_pend  <= req_valid;
			if (ans_pend & ans_write) s_bvalid_o <= 1'b1;
			else if (b_hs) s_bvalid_o <= 1'b0;
			if (ans_pend & ~ans_write) s_rvalid_o <= 1'b1;
			else if (r_hs) s_rvalid_o <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (ar_hs) rd_addr_q <= s_araddr_i;
		if (aw_hs) begin
			req_write <= 1'b1;
			req_addr  <= s_awaddr_i;
			req_wdata <= s_wdata_i;
			req_strb  <= s_wstrb_i;
		end else if (rd_held | ar_hs) begin
			req_write <= 1'b0;
			req_addr  <= rd_held ? rd_addr_q : s_araddr_i;
			req_strb  <= '0;
		end
		ans_write <= req_write;
		if (ans_pend & ans_write) s_bresp_o <= merged_resp;   // held until bready
		if (ans_pend & ~ans_write) begin
			s_rresp_o <= merged_resp;
			s_rdata_o <= merged_data;
		end
	end

	assign req_o = '{valid: req_valid, write: req_write, addr: req_addr,
		wdata: req_wdata, strb: req_strb};

	// at most one part claims an address
	always_comb begin
		any_hit = reg_rsp_i.hit | pal_rsp_i.hit;
		if (reg_rsp_i.hit) merged_data = reg_rsp_i.rdata;
		else if (pal_rsp_i.hit) merged_data = pal_rsp_i.rdata;
		else merged_data = '0;                          // unmapped reads give zero
		if (!any_hit) merged_resp = DECERR;
		else if (reg_rsp_i.ro_violation | pal_rsp_i.ro_violation) merged_resp = SLVERR;
		else merged_resp = OKAY;
	end

endmodule

// File: logic/pvr_top.sv
`timescale 1ns/1ps

module pvr_top #(
	parameter int ADDR_W    = pvr_pkg::ADDR_W,
	parameter int PAL_WORDS = 4096
) (
	input  logic                       clock,
	input  logic                       reset_n,
	input  logic [ADDR_W-1:0]          s_awaddr_i,
	input  logic                       s_awvalid_i,
	output logic                       s_awready_o,
	input  logic [pvr_pkg::DATA_W-1:0] s_wdata_i,
	input  logic [pvr_pkg::STRB_W-1:0] s_wstrb_i,
	input  logic                       s_wvalid_i,
	output logic                       s_wready_o,
	output pvr_pkg::resp_t             s_bresp_o,
	output logic                       s_bvalid_o,
	input  logic                       s_bready_i,
	input  logic [ADDR_W-1:0]          s_araddr_i,
	input  logic                       s_arvalid_i,
	output logic                       s_arready_o,
	output logic [pvr_pkg::DATA_W-1:0] s_rdata_o,
	output pvr_pkg::resp_t             s_rresp_o,
	output logic                       s_rvalid_o,
	input  logic                       s_rready_i,
	output pvr_pkg::parser_cfg_t       cfg_o,          // to the region array parser
	output logic                       start_render_o
);
	import pvr_pkg::*;

	bus_req_t   req;                    // one access, seen by both parts
	store_rsp_t reg_rsp;
	store_rsp_t pal_rsp;

	pvr_axi_slave #(.ADDR_W(ADDR_W)) i_axi_slave (
		.clock, .reset_n,
		.s_awaddr_i, .s_awvalid_i, .s_awready_o,
		.s_wdata_i, .s_wstrb_i, .s_wvalid_i, .s_wready_o,
		.s_bresp_o, .s_bvalid_o, .s_bready_i,
		.s_araddr_i, .s_arvalid_i, .s_arready_o,
		.s_rdata_o, .s_rresp_o, .s_rvalid_o, .s_rready_i,
		.req_o(req), .reg_rsp_i(reg_rsp), .pal_rsp_i(pal_rsp)
	);

	pvr_reg_bank #(.ADDR_W(ADDR_W)) i_reg_bank (
		.clock, .reset_n,
		.req_i(req), .rsp_o(reg_rsp),
		.cfg_o, .start_render_o
	);

	pvr_palette_ram #(.ADDR_W(ADDR_W), .PAL_WORDS(PAL_WORDS)) i_palette_ram (
		.clock, .reset_n,
		.req_i(req), .rsp_o(pal_rsp)
	);

endmodule

// File: test/pvr_assertions.sv
`timescale 1ns/1ps

module pvr_assertions (
	input logic                       clock,
	input logic                       reset_n,
	input logic                       bvalid_i,
	input logic                       bready_i,
	input pvr_pkg::resp_t             bresp_i,
	input logic                       rvalid_i,
	input logic                       rready_i,
	input logic [pvr_pkg::DATA_W-1:0] rdata_i,
	input pvr_pkg::resp_t             rresp_i,
	input logic                       arready_i,
	input logic                       pulse_i
);
	int fails = 0;                                      // summed into the testbench error count

	b_hold: assert property (@(posedge clock) disable iff (!reset_n)
		bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
	else begin
		$error("bvalid dropped or bresp changed while bready low");
		fails++;
	end

	r_hold: assert property (@(posedge clock) disable iff (!reset_n)
		rvalid_i && !rready_i |=> rvalid_i && $stable({rdata_i, rresp_i}))
	else begin
		$error("rvalid dropped or read data changed while rready low");
		fails++;
	end

	ar_blocked: assert property (@(posedge clock) disable iff (!reset_n)
		rvalid_i |-> !arready_i)
	else begin
		$error("arready high with read data pending");
		fails++;
	end

	pulse_short: assert property (@(posedge clock) disable iff (!reset_n)
		pulse_i |=> !pulse_i)
	else begin
		$error("start_render_o high for two cycles");
		fails++;
	end

endmodule

// bus handshake side, render pulse unused here
bind pvr_axi_slave pvr_assertions i_bus_assertions (
	.clock, .reset_n,
	.bvalid_i(s_bvalid_o), .bready_i(s_bready_i), .bresp_i(s_bresp_o),
	.rvalid_i(s_rvalid_o), .rready_i(s_rready_i), .rdata_i(s_rdata_o), .rresp_i(s_rresp_o),
	.arready_i(s_arready_o), .pulse_i(1'b0)
);

bind pvr_reg_bank pvr_assertions i_pulse_assertions (
	.clock, .reset_n,
	.bvalid_i(1'b0), .bready_i(1'b0), .bresp_i(pvr_pkg::OKAY),
	.rvalid_i(1'b0), .rready_i(1'b0), .rdata_i('0), .rresp_i(pvr_pkg::OKAY),
	.arready_i(1'b0), .pulse_i(start_render_o)
);

// File: test/tb_pvr.sv
`timescale 1ns/1ps

module tb_pvr;
	import pvr_pkg::*;

	localparam int PAL_WORDS = 4096;
	localparam int TIMEOUT   = 64;                      // cycles allowed for any single wait

	logic clock;
	logic reset_n;
	logic [ADDR_W-1:0] awaddr;
	logic [ADDR_W-1:0] araddr;
	logic [DATA_W-1:0] wdata;
	logic [DATA_W-1:0] rdata;
	logic [STRB_W-1:0] wstrb;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	resp_t bresp;
	resp_t rresp;
	parser_cfg_t cfg;
	logic start_render;

	logic [DATA_W-1:0] reg_model [logic [ADDR_W-1:0]];  // word address -> contents
	logic [DATA_W-1:0] pal_model [int];                 // palette index -> word, written ones
	int pal_list [$];                                   // indices with a known word
	logic [ADDR_W-1:0] rw_addrs [12] = '{SOFTRESET_ADDR, STARTRENDER_ADDR, PARAM_BASE_ADDR,
		REGION_BASE_ADDR, VO_BORDER_COL_ADDR, FB_W_LINESTRIDE_ADDR, FB_R_SOF1_ADDR,
		FB_W_SOF1_ADDR, FB_X_CLIP_ADDR, FB_Y_CLIP_ADDR, FPU_PARAM_CFG_ADDR, TA_ALLOC_CTRL_ADDR};
	int errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int render_writes = 0;
	int render_pulses = 0;
	logic aw_taken, ar_taken;                           // handshake seen at the last rising edge

	pvr_top #(.ADDR_W(ADDR_W), .PAL_WORDS(PAL_WORDS)) i_dut (
		.clock, .reset_n,
		.s_awaddr_i(awaddr), .s_awvalid_i(awvalid), .s_awready_o(awready),
		.s_wdata_i(wdata), .s_wstrb_i(wstrb), .s_wvalid_i(wvalid), .s_wready_o(wready),
		.s_bresp_o(bresp), .s_bvalid_o(bvalid), .s_bready_i(bready),
		.s_araddr_i(araddr), .s_arvalid_i(arvalid), .s_arready_o(arready),
		.s_rdata_o(rdata), .s_rresp_o(rresp), .s_rvalid_o(rvalid), .s_rready_i(rready),
		.cfg_o(cfg), .start_render_o(start_render)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock) begin
		aw_taken <= awready & wready;                   // aw and w must be taken together
		ar_taken <= arready;
		if (reset_n && start_render) render_pulses <= render_pulses + 1;
	end

	function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
		input logic [DATA_W-1:0] new_w, input logic [STRB_W-1:0] strb);
		logic [DATA_W-1:0] mask;
		for (int b = 0; b < STRB_W; b++) mask[8*b +: 8] = {8{strb[b]}};
		return (old_w & ~mask) | (new_w & mask);
	endfunction

	function automatic logic in_palette(input logic [ADDR_W-1:0] addr);
		return (addr[15:12] == 4'h1) && (int'(addr) < int'(PAL_BASE) + 4 * PAL_WORDS);
	endfunction

	function automatic resp_t expect_resp(input logic [ADDR_W-1:0] addr, input logic is_write);
		logic [ADDR_W-1:0] word;
		word = {addr[ADDR_W-1:2], 2'b00};
		if (reg_model.exists(word)) begin
			if (is_write && (word == ID_ADDR || word == REVISION_ADDR)) return SLVERR;
			return OKAY;
		end
		if (in_palette(addr)) return OKAY;
		return DECERR;                                   // nobody owns it
	endfunction

	function automatic logic [DATA_W-1:0] model_read(input logic [ADDR_W-1:0] addr);
		logic [ADDR_W-1:0] word;
		word = {addr[ADDR_W-1:2], 2'b00};
		if (reg_model.exists(word)) return reg_model[word];
		if (in_palette(addr)) return pal_model[(int'(addr) - int'(PAL_BASE)) / 4];
		return '0;
	endfunction

	function automatic parser_cfg_t expected_cfg();
		parser_cfg_t c;
		c.param_base    = reg_model[PARAM_BASE_ADDR];
		c.region_base   = reg_model[REGION_BASE_ADDR];
		c.fpu_param_cfg = reg_model[FPU_PARAM_CFG_ADDR];
		c.ta_alloc_ctrl = reg_model[TA_ALLOC_CTRL_ADDR];
		return c;
	endfunction

	task automatic model_reset();
		foreach (rw_addrs[i]) reg_model[rw_addrs[i]] = '0;
		reg_model[ID_ADDR]            = DEVICE_ID;
		reg_model[REVISION_ADDR]      = REVISION_ID;
		reg_model[REGION_BASE_ADDR]   = RST_REGION_BASE;
		reg_model[FPU_PARAM_CFG_ADDR] = RST_FPU_PARAM_CFG;
		reg_model[TA_ALLOC_CTRL_ADDR] = RST_TA_ALLOC_CTRL;
	endtask

	task automatic model_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
		input logic [STRB_W-1:0] strb);
		logic [ADDR_W-1:0] word;
		int idx;
		word = {addr[ADDR_W-1:2], 2'b00};
		if (word == STARTRENDER_ADDR) render_writes++;  // pulses even with no strobe
		if (word == ID_ADDR || word == REVISION_ADDR) return;
		if (reg_model.exists(word)) begin
			reg_model[word] = merge_bytes(reg_model[word], data, strb);
		end else if (in_palette(addr)) begin
			idx = (int'(addr) - int'(PAL_BASE)) / 4;
			if (!pal_model.exists(idx)) pal_list.push_back(idx);
			pal_model[idx] = merge_bytes(pal_model.exists(idx) ? pal_model[idx] : '0, data, strb);
		end
	endtask

	task automatic abort_run(input string what);
		$display("timeout: %s", what);
		$display("TESTBENCH FAILED");
		$finish;
	endtask

	task automatic compare(input string name, input string what, input logic [127:0] exp,
		input logic [127:0] act);
		if (exp !== act) begin
			$display("[FAIL] %s %s: expected %0h, actual %0h", name, what, exp, act);
			errors++;
		end
	endtask

	task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
		input logic [STRB_W-1:0] strb, input int hold, output resp_t resp);
		int n;
		@(negedge clock);
		awaddr  = addr;
		wdata   = data;
		wstrb   = strb;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		n = 0;
		do begin
			@(negedge clock);
			n++;
			if (n > TIMEOUT) abort_run("write address and data never accepted");
		end while (!aw_taken);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		n = 0;
		while (!bvalid) begin
			@(negedge clock);
			n++;
			if (n > TIMEOUT) abort_run("no write response");
		end
		repeat (hold) @(negedge clock);                  // stall the b channel
		resp   = bresp;
		bready = 1'b1;
		@(negedge clock);
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [ADDR_W-1:0] addr, input int hold,
		output logic [DATA_W-1:0] data, output resp_t resp);
		int n;
		@(negedge clock);
		araddr  = addr;
		arvalid = 1'b1;
		n = 0;
		do begin
			@(negedge clock);
			n++;
			if (n > TIMEOUT) abort_run("read address never accepted");
		end while (!ar_taken);
		arvalid = 1'b0;
		n = 0;
		while (!rvalid) begin
			@(negedge clock);
			n++;
			if (n > TIMEOUT) abort_run("no read data");
		end
		repeat (hold) @(negedge clock);
		data   = rdata;
		resp   = rresp;
		rready = 1'b1;
		@(negedge clock);
		rready = 1'b0;
	endtask

	task automatic do_write(input string name, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb, input int hold);
		resp_t got;
		resp_t exp;
		exp = expect_resp(addr, 1'b1);
		axi_write(addr, data, strb, hold, got);
		model_write(addr, data, strb);
		compare(name, "bresp", 128'(exp), 128'(got));
		compare(name, "cfg_o", 128'(expected_cfg()), 128'(cfg)); // visible by bvalid
	endtask

	task automatic do_read(input string name, input logic [ADDR_W-1:0] addr, input int hold);
		logic [DATA_W-1:0] got_data;
		logic [DATA_W-1:0] exp_data;
		resp_t got;
		resp_t exp;
		exp      = expect_resp(addr, 1'b0);
		exp_data = model_read(addr);
		axi_read(addr, hold, got_data, got);
		compare(name, "rresp", 128'(exp), 128'(got));
		compare(name, "rdata", 128'(exp_data), 128'(got_data));
	endtask

	task automatic report_test(input string name, input int mark);
		if (errors == mark) begin
			tests_passed++;
			$display("test %-14s ok", name);
		end else begin
			tests_failed++;
			$display("test %-14s %0d errors", name, errors - mark);
		end
	endtask

	initial begin
		int mark;
		int k;
		int idx;
		int hw;
		int hr;
		logic [ADDR_W-1:0] a;
		logic [ADDR_W-1:0] b;
		logic [DATA_W-1:0] d;
		logic [STRB_W-1:0] s;
		void'($urandom(32'hc2e0_df38));
		reset_n = 1'b0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		model_reset();
		repeat (4) @(posedge clock);
		@(negedge clock);
		reset_n = 1'b1;

		mark = errors;
		if (awready || wready || arready || bvalid || rvalid || start_render) begin
			$display("outputs not idle after reset");
			errors++;
		end
		do_read("reset_values", ID_ADDR, 0);
		do_read("reset_values", REVISION_ADDR, 0);
		do_read("reset_values", FPU_PARAM_CFG_ADDR, 0);
		do_read("reset_values", TA_ALLOC_CTRL_ADDR, 0);
		do_read("reset_values", REGION_BASE_ADDR, 0);
		compare("reset_values", "cfg_o", 128'(expected_cfg()), 128'(cfg));
		report_test("reset_values", mark);

		mark = errors;
		for (int i = 0; i < 200; i++) begin
			k = $urandom_range(11, 0);
			d = $urandom;
			s = 4'($urandom_range(15, 0));
			do_write("reg_random", rw_addrs[k], d, s, $urandom_range(3, 0));
			k = $urandom_range(11, 0);
			do_read("reg_random", rw_addrs[k], $urandom_range(3, 0));
		end
		foreach (rw_addrs[i]) do_read("reg_random", rw_addrs[i], 0);
		report_test("reg_random", mark);

		mark = errors;
		for (int i = 0; i < 200; i++) begin
			idx = $urandom_range(1023, 0);                // 4 KB window
			a   = PAL_BASE + 16'(4 * idx);
			if (!pal_model.exists(idx)) do_write("palette", a, $urandom, 4'hF, 0);
			do_write("palette", a, $urandom, 4'($urandom_range(15, 0)), $urandom_range(2, 0));
			do_read("palette", a, $urandom_range(2, 0));
			b = PAL_BASE + 16'(4 * pal_list[$urandom_range(pal_list.size() - 1, 0)]);
			do_read("palette", b, 0);
		end
		report_test("palette", mark);

		mark = errors;
		do_write("errors", ID_ADDR, $urandom, 4'hF, 0);
		do_write("errors", REVISION_ADDR, $urandom, 4'hF, 1);
		do_read("errors", ID_ADDR, 0);
		do_read("errors", REVISION_ADDR, 0);
		do_write("errors", 16'h0F00, $urandom, 4'hF, 0);
		do_write("errors", 16'h2000, $urandom, 4'hF, 0);
		do_read("errors", 16'h0F00, 0);
		do_read("errors", 16'h2000, 2);
		report_test("errors", mark);

		mark = errors;
		for (int i = 0; i < 5; i++) do_write("render_start", STARTRENDER_ADDR, i, 4'hF, 0);
		compare("render_start", "pulses", 128'(render_writes), 128'(render_pulses));
		report_test("render_start", mark);

		mark = errors;
		for (int i = 0; i < 100; i++) begin
			k  = $urandom_range(11, 0);
			d  = $urandom;
			s  = 4'($urandom_range(15, 0));
			hw = $urandom_range(4, 0);
			hr = $urandom_range(4, 0);
			b  = PAL_BASE + 16'(4 * pal_list[$urandom_range(pal_list.size() - 1, 0)]);
			fork
				do_write("overlap", rw_addrs[k], d, s, hw);
				do_read("overlap", b, hr);
			join
		end
		foreach (rw_addrs[i]) do_read("overlap", rw_addrs[i], 0);
		report_test("overlap", mark);

		k = i_dut.i_axi_slave.i_bus_assertions.fails + i_dut.i_reg_bank.i_pulse_assertions.fails;
		if (k != 0) begin
			$display("%0d assertion failures", k);
			errors += k;
		end
		$display("tests: %0d passed, %0d failed, %0d check errors",
			tests_passed, tests_failed, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: tb.f
logic/pvr_pkg.sv
logic/pvr_reg_bank.sv
logic/pvr_palette_ram.sv
logic/pvr_axi_slave.sv
logic/pvr_top.sv
test/pvr_assertions.sv
test/tb_pvr.sv

// File: Makefile
TOP = tb_pvr
OBJ = obj_dir

all: run

compile:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir $(OBJ)

run: compile
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf $(OBJ) sim.log

.PHONY: all compile run clean
